// File: design/mac_lookup_pkg.sv
`default_nettype none

package mac_lookup_pkg;

    localparam int VLAN_W = 12;  // 802.1q vlan id
    localparam int MAC_W  = 48;

    // one address, two decodes
    typedef union packed {
        logic [2:0][15:0] words;   // word 2 is the top 16 bits
        logic [5:0][7:0]  octets;  // octet 5 goes first on the wire
    } mac_addr_u;

    // forwarding kind reported with the tx port mask
    localparam logic [1:0] KIND_UNICAST   = 2'd0;
    localparam logic [1:0] KIND_MULTICAST = 2'd1;
    localparam logic [1:0] KIND_BROADCAST = 2'd2;
    localparam logic [1:0] KIND_FLOOD     = 2'd3;

endpackage

`default_nettype wire

// File: design/frame_class_if.sv
`timescale 1ns/100ps
`default_nettype none

interface frame_class_if #(
    parameter int PORT_NUM = 4
);

    logic                class_vld;   // one cycle per frame
    logic                is_local;    // dmac is the switch itself
    logic [1:0]          mac_kind;    // unicast, multicast or broadcast
    logic [PORT_NUM-1:0] flood_mask;  // every port but the rx one

    modport src (
        output class_vld,
        output is_local,
        output mac_kind,
        output flood_mask
    );

    modport dst (
        input class_vld,
        input is_local,
        input mac_kind,
        input flood_mask
    );

endinterface

`default_nettype wire

// File: design/lookup_set_if.sv
`timescale 1ns/100ps
`default_nettype none

interface lookup_set_if #(
    parameter int PORT_NUM = 4
);

    logic                all_ready;   // all three results in
    logic [PORT_NUM-1:0] smac_port;
    logic [PORT_NUM-1:0] dmac_port;
    logic                dmac_clash;  // dmac entry hit a hash clash
    logic [PORT_NUM-1:0] clash_port;

    modport src (
        output all_ready,
        output smac_port,
        output dmac_port,
        output dmac_clash,
        output clash_port
    );

    modport dst (
        input all_ready,
        input smac_port,
        input dmac_port,
        input dmac_clash,
        input clash_port
    );

endinterface

`default_nettype wire

// File: design/frame_decode.sv
`timescale 1ns/100ps
`default_nettype none

module frame_decode
    import mac_lookup_pkg::*;
#(
    parameter int               PORT_NUM  = 4,
    parameter int               HASH_W    = 12,
    parameter logic [MAC_W-1:0] LOCAL_MAC = 48'h02_00_00_00_00_01
) (
    input  wire logic                i_clk,
    input  wire logic                i_rst,
    input  wire logic                i_frame_vld,
    input  wire logic [VLAN_W-1:0]   i_vlan_id,
    input  wire logic [PORT_NUM-1:0] i_rx_port,
    input  wire logic [MAC_W-1:0]    i_dmac,
    input  wire logic [HASH_W-1:0]   i_dmac_hash,
    input  wire logic [MAC_W-1:0]    i_smac,
    input  wire logic [HASH_W-1:0]   i_smac_hash,
    output logic                     o_dmac_req_vld,
    output logic [HASH_W-1:0]        o_dmac_req_addr,
    output logic [MAC_W-1:0]         o_dmac_req_mac,
    output logic                     o_smac_req_vld,
    output logic [HASH_W-1:0]        o_smac_req_addr,
    output logic [MAC_W-1:0]         o_smac_req_mac,
    output logic [VLAN_W-1:0]        o_req_vlan_id,
    output logic [PORT_NUM-1:0]      o_req_rx_port,
    frame_class_if.src               o_class
);

    localparam mac_addr_u LOCAL_ADDR = LOCAL_MAC;

    logic                r_frame_vld;
    logic [VLAN_W-1:0]   r_vlan_id;
    logic [PORT_NUM-1:0] r_rx_port;
    mac_addr_u           r_dmac;
    logic [HASH_W-1:0]   r_dmac_hash;
    logic [MAC_W-1:0]    r_smac;
    logic [HASH_W-1:0]   r_smac_hash;

    logic                r_cmp_vld;
    logic [2:0]          r_bcast_eq;    // per word all ones
    logic [2:0]          r_local_eq;    // per word equal to own mac
    logic                r_mcast_bit;
    logic [PORT_NUM-1:0] r_flood_mask;

    // frame capture, doubles as the table request
    always_ff @(posedge i_clk or negedge i_rst) begin
        if (!i_rst) begin
            r_frame_vld <= 1'b0;
            r_vlan_id   <= '0;
            r_rx_port   <= '0;
            r_dmac      <= '0;
            r_dmac_hash <= '0;
            r_smac      <= '0;
            r_smac_hash <= '0;
        end else begin
            r_frame_vld <= i_frame_vld;
            if (i_frame_vld) begin
                r_vlan_id   <= i_vlan_id;
                r_rx_port   <= i_rx_port;
                r_dmac      <= i_dmac;
                r_dmac_hash <= i_dmac_hash;
                r_smac      <= i_smac;
                r_smac_hash <= i_smac_hash;
            end
        end
    end

    assign o_dmac_req_vld  = r_frame_vld;
    assign o_dmac_req_addr = r_dmac_hash;
    assign o_dmac_req_mac  = r_dmac;
    assign o_smac_req_vld  = r_frame_vld;
    assign o_smac_req_addr = r_smac_hash;
    assign o_smac_req_mac  = r_smac;
    assign o_req_vlan_id   = r_vlan_id;
    assign o_req_rx_port   = r_rx_port;

    // 16 bit compares keep the 48 bit match off one long path
    always_ff @(posedge i_clk or negedge i_rst) begin
        if (!i_rst) begin
            r_cmp_vld    <= 1'b0;
            r_bcast_eq   <= '0;
            r_local_eq   <= '0;
            r_mcast_bit  <= 1'b0;
            r_flood_mask <= '0;
        end else begin
            r_cmp_vld <= r_frame_vld;
            for (int i = 0; i < 3; i++) begin
                r_bcast_eq[i] <= (r_dmac.words[i] == 16'hffff);
                r_local_eq[i] <= (r_dmac.words[i] == LOCAL_ADDR.words[i]);
            end
            r_mcast_bit  <= r_dmac.octets[5][0];  // i/g bit of first octet
            r_flood_mask <= ~r_rx_port;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst) begin
        if (!i_rst) begin
            o_class.class_vld  <= 1'b0;
            o_class.is_local   <= 1'b0;
            o_class.mac_kind   <= KIND_UNICAST;
            o_class.flood_mask <= '0;
        end else begin
            o_class.class_vld  <= r_cmp_vld;
            o_class.is_local   <= &r_local_eq;
            o_class.flood_mask <= r_flood_mask;
            if (&r_bcast_eq) begin
                o_class.mac_kind <= KIND_BROADCAST;  // broadcast also has the i/g bit
            end else if (r_mcast_bit) begin
                o_class.mac_kind <= KIND_MULTICAST;
            end else begin
                o_class.mac_kind <= KIND_UNICAST;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/lookup_collect.sv
`timescale 1ns/100ps
`default_nettype none

module lookup_collect #(
    parameter int PORT_NUM = 4
) (
    input  wire logic                i_clk,
    input  wire logic                i_rst,
    input  wire logic [PORT_NUM-1:0] i_smac_rslt,
    input  wire logic                i_smac_rslt_vld,
    input  wire logic [PORT_NUM-1:0] i_dmac_rslt,
    input  wire logic                i_dmac_rslt_vld,
    input  wire logic                i_dmac_clash,
    input  wire logic [PORT_NUM-1:0] i_clash_rslt,
    input  wire logic                i_clash_rslt_vld,
    lookup_set_if.src                o_set
);

    logic                ri_smac_vld;
    logic                ri_dmac_vld;
    logic                ri_clash_vld;
    logic [PORT_NUM-1:0] ri_smac_rslt;
    logic [PORT_NUM-1:0] ri_dmac_rslt;
    logic                ri_dmac_clash;
    logic [PORT_NUM-1:0] ri_clash_rslt;

    logic                r_smac_rdy;
    logic                r_dmac_rdy;
    logic                r_clash_rdy;
    logic [PORT_NUM-1:0] r_smac_port;
    logic [PORT_NUM-1:0] r_dmac_port;
    logic                r_dmac_clash;
    logic [PORT_NUM-1:0] r_clash_port;
    logic                r_all_ready;
    logic                w_all_in;

    // strobes arriving this cycle count as ready
    assign w_all_in = (r_smac_rdy | ri_smac_vld) & (r_dmac_rdy | ri_dmac_vld) &
                      (r_clash_rdy | ri_clash_vld);

    always_ff @(posedge i_clk or negedge i_rst) begin
        if (!i_rst) begin
            ri_smac_vld  <= 1'b0;
            ri_dmac_vld  <= 1'b0;
            ri_clash_vld <= 1'b0;
        end else begin
            ri_smac_vld  <= i_smac_rslt_vld;
            ri_dmac_vld  <= i_dmac_rslt_vld;
            ri_clash_vld <= i_clash_rslt_vld;
        end
    end

    always_ff @(posedge i_clk) begin
        ri_smac_rslt  <= i_smac_rslt;
        ri_dmac_rslt  <= i_dmac_rslt;
        ri_dmac_clash <= i_dmac_clash;
        ri_clash_rslt <= i_clash_rslt;
    end

    always_ff @(posedge i_clk or negedge i_rst) begin
        if (!i_rst) begin
            r_smac_rdy  <= 1'b0;
            r_dmac_rdy  <= 1'b0;
            r_clash_rdy <= 1'b0;
            r_all_ready <= 1'b0;
        end else begin
            r_all_ready <= w_all_in & ~r_all_ready;
            if (w_all_in) begin  // set is complete, start over
                r_smac_rdy  <= 1'b0;
                r_dmac_rdy  <= 1'b0;
                r_clash_rdy <= 1'b0;
            end else begin
                r_smac_rdy  <= r_smac_rdy | ri_smac_vld;
                r_dmac_rdy  <= r_dmac_rdy | ri_dmac_vld;
                r_clash_rdy <= r_clash_rdy | ri_clash_vld;
            end
        end
    end

    // results stay put through the all_ready cycle
    always_ff @(posedge i_clk or negedge i_rst) begin
        if (!i_rst) begin
            r_smac_port  <= '0;
            r_dmac_port  <= '0;
            r_dmac_clash <= 1'b0;
            r_clash_port <= '0;
        end else if (r_all_ready) begin
            r_smac_port  <= '0;
            r_dmac_port  <= '0;
            r_dmac_clash <= 1'b0;
            r_clash_port <= '0;
        end else begin
            if (ri_smac_vld) begin
                r_smac_port <= ri_smac_rslt;
            end
            if (ri_dmac_vld) begin
                r_dmac_port  <= ri_dmac_rslt;
                r_dmac_clash <= ri_dmac_clash;  // travels with the dmac result
            end
            if (ri_clash_vld) begin
                r_clash_port <= ri_clash_rslt;
            end
        end
    end

    assign o_set.all_ready  = r_all_ready;
    assign o_set.smac_port  = r_smac_port;
    assign o_set.dmac_port  = r_dmac_port;
    assign o_set.dmac_clash = r_dmac_clash;
    assign o_set.clash_port = r_clash_port;

endmodule

`default_nettype wire

// File: design/port_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module port_arbiter
    import mac_lookup_pkg::*;
#(
    parameter int PORT_NUM = 4
) (
    input  wire logic       i_clk,
    input  wire logic       i_rst,
    frame_class_if.dst      i_class,
    lookup_set_if.dst       i_set,
    output logic [PORT_NUM:0] o_tx_port,      // top bit marks a frame to the switch
    output logic            o_tx_port_vld,
    output logic [1:0]      o_tx_kind
);

    logic                r_is_local;
    logic [1:0]          r_mac_kind;
    logic [PORT_NUM-1:0] r_flood_mask;

    logic [PORT_NUM-1:0] w_pick;
    logic [1:0]          w_kind;

    always_ff @(posedge i_clk or negedge i_rst) begin
        if (!i_rst) begin
            r_is_local   <= 1'b0;
            r_mac_kind   <= KIND_UNICAST;
            r_flood_mask <= '0;
        end else if (i_class.class_vld) begin
            r_is_local   <= i_class.is_local;
            r_mac_kind   <= i_class.mac_kind;
            r_flood_mask <= i_class.flood_mask;
        end
    end

    // smac first, then a clean dmac hit, then the clash table
    always_comb begin
        if (i_set.smac_port != '0) begin
            w_pick = i_set.smac_port;
        end else if (i_set.dmac_port != '0 && !i_set.dmac_clash) begin
            w_pick = i_set.dmac_port;
        end else if (i_set.clash_port != '0) begin
            w_pick = i_set.clash_port;
        end else begin
            w_pick = r_flood_mask;
        end
    end

    always_comb begin
        if (r_mac_kind != KIND_UNICAST || r_is_local) begin
            w_kind = r_mac_kind;
        end else if (w_pick == r_flood_mask && r_flood_mask != '0) begin
            w_kind = KIND_FLOOD;  // lookup gave nothing better than flooding
        end else begin
            w_kind = KIND_UNICAST;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst) begin
        if (!i_rst) begin
            o_tx_port     <= '0;
            o_tx_port_vld <= 1'b0;
            o_tx_kind     <= KIND_UNICAST;
        end else begin
            o_tx_port_vld <= i_set.all_ready;
            if (i_set.all_ready) begin
                o_tx_kind <= w_kind;
                if (r_is_local) begin
                    o_tx_port <= {1'b1, {PORT_NUM{1'b0}}};
                end else begin
                    o_tx_port <= {1'b0, w_pick};
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: design/mac_lookup_mng.sv
`timescale 1ns/100ps
`default_nettype none

module mac_lookup_mng
    import mac_lookup_pkg::*;
#(
    parameter int               PORT_NUM  = 4,
    parameter int               HASH_W    = 12,
    parameter logic [MAC_W-1:0] LOCAL_MAC = 48'h02_00_00_00_00_01
) (
    input  wire logic                i_clk,
    input  wire logic                i_rst,
    // frame from the parser
    input  wire logic                i_frame_vld,
    input  wire logic [VLAN_W-1:0]   i_vlan_id,
    input  wire logic [PORT_NUM-1:0] i_rx_port,      // one hot
    input  wire logic [MAC_W-1:0]    i_dmac,
    input  wire logic [HASH_W-1:0]   i_dmac_hash,
    input  wire logic [MAC_W-1:0]    i_smac,
    input  wire logic [HASH_W-1:0]   i_smac_hash,
    // table requests, clash table shares the dmac one
    output logic                     o_dmac_req_vld,
    output logic [HASH_W-1:0]        o_dmac_req_addr,
    output logic [MAC_W-1:0]         o_dmac_req_mac,
    output logic                     o_smac_req_vld,
    output logic [HASH_W-1:0]        o_smac_req_addr,
    output logic [MAC_W-1:0]         o_smac_req_mac,
    output logic [VLAN_W-1:0]        o_req_vlan_id,
    output logic [PORT_NUM-1:0]      o_req_rx_port,
    // table results
    input  wire logic [PORT_NUM-1:0] i_smac_rslt,
    input  wire logic                i_smac_rslt_vld,
    input  wire logic [PORT_NUM-1:0] i_dmac_rslt,
    input  wire logic                i_dmac_rslt_vld,
    input  wire logic                i_dmac_clash,
    input  wire logic [PORT_NUM-1:0] i_clash_rslt,
    input  wire logic                i_clash_rslt_vld,
    // forwarding decision
    output logic [PORT_NUM:0]        o_tx_port,
    output logic                     o_tx_port_vld,
    output logic [1:0]               o_tx_kind
);

    frame_class_if #(.PORT_NUM(PORT_NUM)) u_class_if ();
    lookup_set_if  #(.PORT_NUM(PORT_NUM)) u_set_if ();

    frame_decode #(
        .PORT_NUM  (PORT_NUM),
        .HASH_W    (HASH_W),
        .LOCAL_MAC (LOCAL_MAC)
    ) u_frame_decode (
        .i_clk           (i_clk),
        .i_rst           (i_rst),
        .i_frame_vld     (i_frame_vld),
        .i_vlan_id       (i_vlan_id),
        .i_rx_port       (i_rx_port),
        .i_dmac          (i_dmac),
        .i_dmac_hash     (i_dmac_hash),
        .i_smac          (i_smac),
        .i_smac_hash     (i_smac_hash),
        .o_dmac_req_vld  (o_dmac_req_vld),
        .o_dmac_req_addr (o_dmac_req_addr),
        .o_dmac_req_mac  (o_dmac_req_mac),
        .o_smac_req_vld  (o_smac_req_vld),
        .o_smac_req_addr (o_smac_req_addr),
        .o_smac_req_mac  (o_smac_req_mac),
        .o_req_vlan_id   (o_req_vlan_id),
        .o_req_rx_port   (o_req_rx_port),
        .o_class         (u_class_if.src)
    );

    lookup_collect #(
        .PORT_NUM (PORT_NUM)
    ) u_lookup_collect (
        .i_clk            (i_clk),
        .i_rst            (i_rst),
        .i_smac_rslt      (i_smac_rslt),
        .i_smac_rslt_vld  (i_smac_rslt_vld),
        .i_dmac_rslt      (i_dmac_rslt),
        .i_dmac_rslt_vld  (i_dmac_rslt_vld),
        .i_dmac_clash     (i_dmac_clash),
        .i_clash_rslt     (i_clash_rslt),
        .i_clash_rslt_vld (i_clash_rslt_vld),
        .o_set            (u_set_if.src)
    );

    port_arbiter #(
        .PORT_NUM (PORT_NUM)
    ) u_port_arbiter (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_class       (u_class_if.dst),
        .i_set         (u_set_if.dst),
        .o_tx_port     (o_tx_port),
        .o_tx_port_vld (o_tx_port_vld),
        .o_tx_kind     (o_tx_kind)
    );

endmodule

`default_nettype wire

// File: bench/tb_mac_lookup_mng.sv
`timescale 1ns/100ps
`default_nettype none

module tb_mac_lookup_mng
    import mac_lookup_pkg::*;
();

    localparam int               PORT_NUM  = 4;
    localparam int               HASH_W    = 12;
    localparam logic [MAC_W-1:0] LOCAL_MAC = 48'h02_1a_2b_3c_4d_5e;
    localparam int               N_FRAMES  = 300;
    localparam int               WAIT_MAX  = 40;  // cycles allowed per frame

    logic                i_clk;
    logic                i_rst;
    logic                i_frame_vld;
    logic [VLAN_W-1:0]   i_vlan_id;
    logic [PORT_NUM-1:0] i_rx_port;
    logic [MAC_W-1:0]    i_dmac;
    logic [HASH_W-1:0]   i_dmac_hash;
    logic [MAC_W-1:0]    i_smac;
    logic [HASH_W-1:0]   i_smac_hash;
    logic                o_dmac_req_vld;
    logic [HASH_W-1:0]   o_dmac_req_addr;
    logic [MAC_W-1:0]    o_dmac_req_mac;
    logic                o_smac_req_vld;
    logic [HASH_W-1:0]   o_smac_req_addr;
    logic [MAC_W-1:0]    o_smac_req_mac;
    logic [VLAN_W-1:0]   o_req_vlan_id;
    logic [PORT_NUM-1:0] o_req_rx_port;
    logic [PORT_NUM-1:0] i_smac_rslt;
    logic                i_smac_rslt_vld;
    logic [PORT_NUM-1:0] i_dmac_rslt;
    logic                i_dmac_rslt_vld;
    logic                i_dmac_clash;
    logic [PORT_NUM-1:0] i_clash_rslt;
    logic                i_clash_rslt_vld;
    logic [PORT_NUM:0]   o_tx_port;
    logic                o_tx_port_vld;
    logic [1:0]          o_tx_kind;

    integer seed;
    int     err_cnt;
    int     chk_cnt;
    bit     timed_out;

    mac_lookup_mng #(
        .PORT_NUM  (PORT_NUM),
        .HASH_W    (HASH_W),
        .LOCAL_MAC (LOCAL_MAC)
    ) i_mac_lookup_mng (
        .i_clk            (i_clk),
        .i_rst            (i_rst),
        .i_frame_vld      (i_frame_vld),
        .i_vlan_id        (i_vlan_id),
        .i_rx_port        (i_rx_port),
        .i_dmac           (i_dmac),
        .i_dmac_hash      (i_dmac_hash),
        .i_smac           (i_smac),
        .i_smac_hash      (i_smac_hash),
        .o_dmac_req_vld   (o_dmac_req_vld),
        .o_dmac_req_addr  (o_dmac_req_addr),
        .o_dmac_req_mac   (o_dmac_req_mac),
        .o_smac_req_vld   (o_smac_req_vld),
        .o_smac_req_addr  (o_smac_req_addr),
        .o_smac_req_mac   (o_smac_req_mac),
        .o_req_vlan_id    (o_req_vlan_id),
        .o_req_rx_port    (o_req_rx_port),
        .i_smac_rslt      (i_smac_rslt),
        .i_smac_rslt_vld  (i_smac_rslt_vld),
        .i_dmac_rslt      (i_dmac_rslt),
        .i_dmac_rslt_vld  (i_dmac_rslt_vld),
        .i_dmac_clash     (i_dmac_clash),
        .i_clash_rslt     (i_clash_rslt),
        .i_clash_rslt_vld (i_clash_rslt_vld),
        .o_tx_port        (o_tx_port),
        .o_tx_port_vld    (o_tx_port_vld),
        .o_tx_kind        (o_tx_kind)
    );

    always #50 i_clk = ~i_clk;

    task automatic check_value(input string name, input logic [63:0] exp_val,
                               input logic [63:0] act_val);
        chk_cnt++;
        if (exp_val !== act_val) begin
            err_cnt++;
            $display("CHECK FAILED %s expected %0h actual %0h", name, exp_val, act_val);
        end
    endtask

    function automatic logic [MAC_W-1:0] rand_mac48();
        logic [31:0] r_hi;
        logic [31:0] r_lo;
        r_hi = $random(seed);
        r_lo = $random(seed);
        return {r_hi[15:0], r_lo};
    endfunction

    // mix of local, broadcast, group and plain unicast addresses
    function automatic logic [MAC_W-1:0] rand_dmac();
        logic [31:0]      r_sel;
        logic [MAC_W-1:0] mac;
        r_sel = $random(seed);
        mac   = rand_mac48();
        case (r_sel[1:0])
            2'd0:    mac = LOCAL_MAC;
            2'd1:    mac = '1;
            2'd2:    mac[40] = 1'b1;  // i/g bit of first octet
            default: mac[40] = 1'b0;
        endcase
        return mac;
    endfunction

    // zero half the time, so lower priority sources get picked
    function automatic logic [PORT_NUM-1:0] rand_mask();
        logic [31:0] r;
        r = $random(seed);
        return r[4] ? '0 : r[PORT_NUM-1:0];
    endfunction

    task automatic predict_decision(input logic [MAC_W-1:0] dmac, input logic [PORT_NUM-1:0] rx,
                                    input logic [PORT_NUM-1:0] smac_p,
                                    input logic [PORT_NUM-1:0] dmac_p, input logic clash_f,
                                    input logic [PORT_NUM-1:0] clash_p,
                                    output logic [PORT_NUM:0] exp_port,
                                    output logic [1:0] exp_kind);
        logic [PORT_NUM-1:0] flood;
        logic [PORT_NUM-1:0] pick;
        logic [1:0]          cls;
        flood = ~rx;
        if (smac_p != 0) pick = smac_p;
        else if (dmac_p != 0 && !clash_f) pick = dmac_p;
        else if (clash_p != 0) pick = clash_p;
        else pick = flood;
        if (dmac == {MAC_W{1'b1}}) cls = KIND_BROADCAST;
        else if (dmac[40]) cls = KIND_MULTICAST;
        else cls = KIND_UNICAST;
        if (dmac == LOCAL_MAC) begin
            exp_port = {1'b1, {PORT_NUM{1'b0}}};
            exp_kind = cls;
        end else begin
            exp_port = {1'b0, pick};
            if (cls != KIND_UNICAST) exp_kind = cls;
            else if (pick == flood && flood != 0) exp_kind = KIND_FLOOD;
            else exp_kind = KIND_UNICAST;
        end
    endtask

    task automatic idle_cycles(input int n, input string name);
        repeat (n) begin
            @(posedge i_clk);
            @(negedge i_clk);
            check_value(name, 0, o_tx_port_vld);
        end
    endtask

    task automatic run_frame(input int frame_no);
        logic [MAC_W-1:0]    dmac;
        logic [MAC_W-1:0]    smac;
        logic [PORT_NUM-1:0] rx;
        logic [PORT_NUM-1:0] smac_p;
        logic [PORT_NUM-1:0] dmac_p;
        logic [PORT_NUM-1:0] clash_p;
        logic [PORT_NUM:0]   exp_port;
        logic [1:0]          exp_kind;
        logic [31:0]         r;
        logic [31:0]         r_junk;
        int                  d_smac;
        int                  d_dmac;
        int                  d_clash;
        int                  last_d;
        int                  t;
        bit                  seen;
        r       = $random(seed);
        rx      = '0;
        rx[r[1:0]] = 1'b1;
        dmac    = rand_dmac();
        smac    = rand_mac48();
        smac_p  = rand_mask();
        dmac_p  = rand_mask();
        clash_p = rand_mask();
        d_smac  = 4 + ($unsigned($random(seed)) % 9);
        d_dmac  = 4 + ($unsigned($random(seed)) % 9);
        d_clash = 4 + ($unsigned($random(seed)) % 9);
        if (r[3:2] == 2'b00) begin  // all three strobes in one cycle
            d_dmac  = d_smac;
            d_clash = d_smac;
        end
        last_d = d_smac;
        if (d_dmac > last_d) last_d = d_dmac;
        if (d_clash > last_d) last_d = d_clash;
        predict_decision(dmac, rx, smac_p, dmac_p, r[4], clash_p, exp_port, exp_kind);

        @(posedge i_clk);
        i_frame_vld <= 1'b1;
        i_vlan_id   <= r[27:16];
        i_rx_port   <= rx;
        i_dmac      <= dmac;
        i_dmac_hash <= r[15:4];
        i_smac      <= smac;
        i_smac_hash <= {r[31:28], r[23:16]};
        seen = 1'b0;
        for (t = 1; t <= WAIT_MAX && !seen; t++) begin
            @(posedge i_clk);
            r_junk = $random(seed);  // noise on result buses outside the strobe
            i_frame_vld      <= 1'b0;
            i_smac_rslt_vld  <= (t == d_smac);
            i_smac_rslt      <= (t == d_smac) ? smac_p : r_junk[3:0];
            i_dmac_rslt_vld  <= (t == d_dmac);
            i_dmac_rslt      <= (t == d_dmac) ? dmac_p : r_junk[7:4];
            i_dmac_clash     <= (t == d_dmac) ? r[4] : r_junk[12];
            i_clash_rslt_vld <= (t == d_clash);
            i_clash_rslt     <= (t == d_clash) ? clash_p : r_junk[11:8];
            @(negedge i_clk);
            if (t == 1) begin
                check_value($sformatf("frame %0d dmac_req_vld", frame_no), 1, o_dmac_req_vld);
                check_value($sformatf("frame %0d smac_req_vld", frame_no), 1, o_smac_req_vld);
                check_value($sformatf("frame %0d dmac_req_addr", frame_no), r[15:4],
                            o_dmac_req_addr);
                check_value($sformatf("frame %0d smac_req_addr", frame_no),
                            {r[31:28], r[23:16]}, o_smac_req_addr);
                check_value($sformatf("frame %0d dmac_req_mac", frame_no), dmac, o_dmac_req_mac);
                check_value($sformatf("frame %0d smac_req_mac", frame_no), smac, o_smac_req_mac);
                check_value($sformatf("frame %0d req_vlan_id", frame_no), r[27:16],
                            o_req_vlan_id);
                check_value($sformatf("frame %0d req_rx_port", frame_no), rx, o_req_rx_port);
            end
            if (o_tx_port_vld) begin
                seen = 1'b1;
                check_value($sformatf("frame %0d latency", frame_no), last_d + 3, t);
                check_value($sformatf("frame %0d tx_port", frame_no), exp_port, o_tx_port);
                check_value($sformatf("frame %0d tx_kind", frame_no), exp_kind, o_tx_kind);
            end
        end
        if (!seen) begin
            err_cnt++;
            timed_out = 1'b1;
            $display("timeout: frame %0d never got o_tx_port_vld", frame_no);
        end else begin
            idle_cycles(1, $sformatf("frame %0d tx_port_vld width", frame_no));
        end
    endtask

    initial begin
        logic [31:0] r_gap;
        seed      = 67583;
        err_cnt   = 0;
        chk_cnt   = 0;
        timed_out = 1'b0;
        i_clk            = 1'b0;
        i_rst            = 1'b0;
        i_frame_vld      = 1'b0;
        i_vlan_id        = '0;
        i_rx_port        = '0;
        i_dmac           = '0;
        i_dmac_hash      = '0;
        i_smac           = '0;
        i_smac_hash      = '0;
        i_smac_rslt      = '0;
        i_smac_rslt_vld  = 1'b0;
        i_dmac_rslt      = '0;
        i_dmac_rslt_vld  = 1'b0;
        i_dmac_clash     = 1'b0;
        i_clash_rslt     = '0;
        i_clash_rslt_vld = 1'b0;

        repeat (16) begin
            @(posedge i_clk);
            @(negedge i_clk);
            check_value("reset tx_port_vld", 0, o_tx_port_vld);
            check_value("reset dmac_req_vld", 0, o_dmac_req_vld);
            check_value("reset smac_req_vld", 0, o_smac_req_vld);
        end
        @(posedge i_clk);
        i_rst <= 1'b1;
        idle_cycles(4, "idle tx_port_vld");
        check_value("idle dmac_req_vld", 0, o_dmac_req_vld);
        check_value("idle smac_req_vld", 0, o_smac_req_vld);
        check_value("idle tx_port", 0, o_tx_port);
        check_value("idle tx_kind", 0, o_tx_kind);

        for (int f = 0; f < N_FRAMES && !timed_out; f++) begin
            run_frame(f);
            r_gap = $random(seed);
            idle_cycles(r_gap[1:0], "gap tx_port_vld");
        end

        $display("errors: %0d, checks: %0d", err_cnt, chk_cnt);
        if (err_cnt == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
design/mac_lookup_pkg.sv
design/frame_class_if.sv
design/lookup_set_if.sv
design/frame_decode.sv
design/lookup_collect.sv
design/port_arbiter.sv
design/mac_lookup_mng.sv
bench/tb_mac_lookup_mng.sv
